//--- project.f
+incdir+verilog
+incdir+tb
verilog/cam_pixel_pkg.sv
verilog/cam_timing_pkg.sv
verilog/cmos_capture_ctrl.sv
verilog/cmos_pixel_assembler.sv
verilog/color_bar_inserter.sv
verilog/cmos_capture_top.sv
tb/tb_cmos_capture.sv

//--- Bender.yml
package:
  name: cmos_capture

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cam_pixel_pkg.sv
      - verilog/cam_timing_pkg.sv
      - verilog/cmos_capture_ctrl.sv
      - verilog/cmos_pixel_assembler.sv
      - verilog/color_bar_inserter.sv
      - verilog/cmos_capture_top.sv
  - target: test
    include_dirs:
      - verilog
      - tb
    files:
      - tb/tb_cmos_capture.sv

//--- tb/tb_cmos_tasks.svh
// Camera driver, compare and directed test tasks that sit inside the testbench module
// Drivers return 2 ns after a rising edge, where the next input change goes
`ifndef TB_CMOS_TASKS_SVH
`define TB_CMOS_TASKS_SVH

// ======================================================================
// Camera driver
// ======================================================================

task automatic next_cycle();
	@(posedge cmos1_pclk);
	#2;
endtask

task automatic idle_cycles(input int n);
	repeat (n) next_cycle();
endtask

task automatic send_vsync();
	next_cycle();
	i_cmos_vsync = 1'b1;
	idle_cycles(4);
	i_cmos_vsync = 1'b0;
	idle_cycles(4);
endtask

task automatic random_line(input int n);
	line_q.delete();
	repeat (n) line_q.push_back(cam_byte_t'($urandom()));
endtask

// One byte per cycle with href high, then a gap
task automatic send_line();
	foreach (line_q[i]) begin
		next_cycle();
		i_cmos_href = 1'b1;
		i_cmos_data = line_q[i];
	end
	next_cycle();
	i_cmos_href = 1'b0;
	i_cmos_data = '0;
	idle_cycles(6);
endtask

// ======================================================================
// Bounded waits
// ======================================================================

task automatic wait_pixels(input int n);
	int waited;
	waited = 0;
	while (pix_q.size() < n) begin
		if (waited >= CYCLE_TIMEOUT)
			stop_with_failure($sformatf("Timed out waiting for %0d pixels, only %0d came out",
				n, pix_q.size()));
		next_cycle();
		waited++;
	end
endtask

task automatic wait_frames(input int n);
	int waited;
	waited = 0;
	while (frame_cnt < n) begin
		if (waited >= CYCLE_TIMEOUT)
			stop_with_failure("Timed out waiting for a frame start pulse");
		next_cycle();
		waited++;
	end
endtask

task automatic wait_line_low();
	int waited;
	waited = 0;
	while (o_line_active) begin
		if (waited >= CYCLE_TIMEOUT)
			stop_with_failure("Timed out waiting for line active to drop after a line");
		next_cycle();
		waited++;
	end
endtask

// ======================================================================
// Compare tasks
// ======================================================================

task automatic check_pixel(input string name, input rgb565_t got, input rgb565_t exp);
	if (got !== exp)
		stop_with_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
			$time, name, got, exp));
endtask

task automatic check_count(input string name, input int got, input int exp);
	if (got != exp)
		stop_with_failure($sformatf("Mismatch at %0t: %s got %0d expected %0d",
			$time, name, got, exp));
endtask

// Red and blue trade places while green stays
function automatic rgb565_t swap_fields(input rgb565_t p);
	logic [4:0] red;
	logic [5:0] green;
	logic [4:0] blue;
	red   = p[15:11];
	green = p[10:5];
	blue  = p[4:0];
	return {blue, green, red};
endfunction

// First byte of each pair is the high byte, an odd last byte is dropped
task automatic check_pairs(input logic swap);
	rgb565_t exp;
	int      npix;
	npix = line_q.size() / 2;
	wait_pixels(npix);
	idle_cycles(8);
	check_count("pixel count", pix_q.size(), npix);
	for (int i = 0; i < npix; i++) begin
		exp = {line_q[2*i], line_q[2*i+1]};
		if (swap)
			exp = swap_fields(exp);
		check_pixel($sformatf("o_pix_data[%0d]", i), pix_q[i], exp);
	end
endtask

task automatic check_bars(input int npix);
	wait_pixels(npix);
	idle_cycles(8);
	check_count("pixel count", pix_q.size(), npix);
	for (int i = 0; i < npix; i++)
		check_pixel($sformatf("o_pix_data[%0d]", i), pix_q[i], BAR_COLOR[i / `CAM_BAR_WIDTH]);
endtask

// ======================================================================
// Directed tests
// ======================================================================

task automatic test_idle_after_reset();
	$display("Test: nothing comes out before the first frame start");
	check_pixel("o_pix_data", o_pix_data, '0);
	random_line(12);
	send_line();
	random_line(7);
	send_line();
	idle_cycles(10);
	check_count("pixels before frame", pix_q.size(), 0);
	check_count("o_frame_start pulses", frame_cnt, 0);
	check_count("o_line_active rises", line_rise_cnt, 0);
	check_pixel("o_pix_data", o_pix_data, '0);
endtask

task automatic test_byte_pairing();
	int frames0;
	$display("Test: byte pairs become pixels in order");
	frames0 = frame_cnt;
	send_vsync();
	wait_frames(frames0 + 1);
	pix_q.delete();
	random_line(21);  // Odd length
	send_line();
	check_pairs(1'b0);
	pix_q.delete();
	random_line(32);
	send_line();
	check_pairs(1'b0);
endtask

task automatic test_swap_rb();
	$display("Test: red and blue swap");
	i_swap_rb = 1'b1;
	pix_q.delete();
	random_line(40);
	send_line();
	check_pairs(1'b1);
	i_swap_rb = 1'b0;
endtask

task automatic test_color_bars();
	$display("Test: colour bars over a full line and a short one");
	i_pattern_en = 1'b1;
	pix_q.delete();
	random_line(2 * `CAM_H_PIXELS);
	send_line();
	check_bars(`CAM_H_PIXELS);
	pix_q.delete();
	random_line(400);  // Restarts at bar 0, ends inside bar 1
	send_line();
	check_bars(200);
	i_pattern_en = 1'b0;
endtask

task automatic test_frame_and_line();
	int frames0;
	int lines;
	$display("Test: frame start pulses and line active over three frames");
	frames0 = frame_cnt;
	lines = line_rise_cnt;
	for (int f = 1; f <= 3; f++) begin
		send_vsync();
		wait_frames(frames0 + f);
		idle_cycles(4);
		check_count("o_frame_start pulses", frame_cnt, frames0 + f);
		repeat (2) begin
			random_line(10);
			send_line();
			wait_line_low();
			lines++;
			check_count("o_line_active rises", line_rise_cnt, lines);
		end
	end
	idle_cycles(6);
	check_count("o_frame_start pulses", frame_cnt, frames0 + 3);
	check_count("o_line_active rises", line_rise_cnt, lines);
endtask

`endif

//--- tb/tb_cmos_capture.sv
// Directed testbench for the camera capture top level
// Drives one camera byte per clock while href is high and stops at the first error
`timescale 1ns/1ps
`include "cam_settings.svh"

module tb_cmos_capture
	import cam_pixel_pkg::*;
();

	localparam int CYCLE_TIMEOUT = 4000;  // Per wait, in clock cycles

	// DUT ports
	logic      cmos1_pclk;
	logic      core_rst_n;
	logic      i_cmos_vsync;
	logic      i_cmos_href;
	cam_byte_t i_cmos_data;
	logic      i_swap_rb;
	logic      i_pattern_en;
	logic      o_pix_vld;
	rgb565_t   o_pix_data;
	logic      o_frame_start;
	logic      o_line_active;

	// Monitor results
	rgb565_t   pix_q[$];
	int        frame_cnt = 0;
	int        line_rise_cnt = 0;
	logic      line_prev = 1'b0;

	// Bytes of the line being driven
	cam_byte_t line_q[$];

	// ==================================================================
	// Clock, DUT and output monitor
	// ==================================================================

	always #20 cmos1_pclk = ~cmos1_pclk;

	cmos_capture_top i_dut (
		.cmos1_pclk    (cmos1_pclk),
		.core_rst_n    (core_rst_n),
		.i_cmos_vsync  (i_cmos_vsync),
		.i_cmos_href   (i_cmos_href),
		.i_cmos_data   (i_cmos_data),
		.i_swap_rb     (i_swap_rb),
		.i_pattern_en  (i_pattern_en),
		.o_pix_vld     (o_pix_vld),
		.o_pix_data    (o_pix_data),
		.o_frame_start (o_frame_start),
		.o_line_active (o_line_active)
	);

	// Outputs settle after the rising edge, so look at them on the falling one
	always @(negedge cmos1_pclk) begin
		if (core_rst_n) begin
			if (o_pix_vld)
				pix_q.push_back(o_pix_data);
			if (o_frame_start)
				frame_cnt++;
			if (o_line_active && !line_prev)
				line_rise_cnt++;  // One per line
			line_prev = o_line_active;
		end
	end

	// ==================================================================
	// Error stop
	// ==================================================================

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "Stopped at the first error");
	endtask

	`include "tb_cmos_tasks.svh"

	// ==================================================================
	// Test sequence
	// ==================================================================

	initial begin
		cmos1_pclk   = 1'b0;
		core_rst_n   = 1'b0;
		i_cmos_vsync = 1'b0;
		i_cmos_href  = 1'b0;
		i_cmos_data  = '0;
		i_swap_rb    = 1'b0;
		i_pattern_en = 1'b0;
		void'($urandom(24177));

		repeat (5) @(posedge cmos1_pclk);
		#2;
		core_rst_n = 1'b1;

		test_idle_after_reset();
		test_byte_pairing();
		test_swap_rb();
		test_color_bars();
		test_frame_and_line();

		$display("PASS: all tests");
		$finish;
	end

endmodule

//--- verilog/cmos_capture_top.sv
// Camera capture path running entirely in the pixel clock domain; the camera cannot be stalled
// Pixels leave 3 cycles after their second byte is sampled
`timescale 1ns/1ps

module cmos_capture_top
	import cam_pixel_pkg::*;
	import cam_timing_pkg::*;
(
	input  logic      cmos1_pclk,
	input  logic      core_rst_n,
	input  logic      i_cmos_vsync,
	input  logic      i_cmos_href,
	input  cam_byte_t i_cmos_data,
	input  logic      i_swap_rb,
	input  logic      i_pattern_en,
	output logic      o_pix_vld,
	output rgb565_t   o_pix_data,
	output logic      o_frame_start,
	output logic      o_line_active
);

	logic     hi_byte_we;
	logic     pair_done;
	pix_pos_t pix_pos;
	logic     frame_start;
	logic     line_active;
	logic     asm_pix_vld;
	rgb565_t  asm_pix_data;

	cmos_capture_ctrl u_ctrl (
		.i_clk         (cmos1_pclk),
		.i_rst_n       (core_rst_n),
		.i_vsync       (i_cmos_vsync),
		.i_href        (i_cmos_href),
		.i_pix_vld     (asm_pix_vld),
		.o_hi_byte_we  (hi_byte_we),
		.o_pair_done   (pair_done),
		.o_pix_pos     (pix_pos),
		.o_frame_start (frame_start),
		.o_line_active (line_active)
	);

	cmos_pixel_assembler u_assembler (
		.i_clk        (cmos1_pclk),
		.i_rst_n      (core_rst_n),
		.i_data       (i_cmos_data),
		.i_hi_byte_we (hi_byte_we),
		.i_pair_done  (pair_done),
		.i_swap_rb    (i_swap_rb),
		.o_pix_vld    (asm_pix_vld),
		.o_pix_data   (asm_pix_data)
	);

	color_bar_inserter u_bar (
		.i_clk         (cmos1_pclk),
		.i_rst_n       (core_rst_n),
		.i_pix_vld     (asm_pix_vld),
		.i_pix_data    (asm_pix_data),
		.i_pix_pos     (pix_pos),
		.i_pattern_en  (i_pattern_en),
		.i_frame_start (frame_start),
		.i_line_active (line_active),
		.o_pix_vld     (o_pix_vld),
		.o_pix_data    (o_pix_data),
		.o_frame_start (o_frame_start),
		.o_line_active (o_line_active)
	);

endmodule

//--- verilog/color_bar_inserter.sv
// Output stage; pattern select is a static level, changing it mid-line mixes sources
// Positions at or past the last bar start all map to the last colour
`timescale 1ns/1ps
`include "cam_settings.svh"

module color_bar_inserter
	import cam_pixel_pkg::*;
	import cam_timing_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_rst_n,
	input  logic     i_pix_vld,
	input  rgb565_t  i_pix_data,
	input  pix_pos_t i_pix_pos,
	input  logic     i_pattern_en,
	input  logic     i_frame_start,
	input  logic     i_line_active,
	output logic     o_pix_vld,
	output rgb565_t  o_pix_data,
	output logic     o_frame_start,
	output logic     o_line_active
);

	localparam int BAR_IDX_W = $clog2(`CAM_BAR_COUNT);
	localparam pix_pos_t BAR_WIDTH = pix_pos_t'(`CAM_BAR_WIDTH);
	localparam pix_pos_t LAST_BAR_START = pix_pos_t'(`CAM_H_PIXELS - `CAM_BAR_WIDTH);
	localparam logic [BAR_IDX_W-1:0] LAST_BAR_IDX = BAR_IDX_W'(`CAM_BAR_COUNT - 1);

	pix_pos_t             bar_quot;
	logic [BAR_IDX_W-1:0] bar_idx;
	rgb565_t              bar_color;
	rgb565_t              pix_sel;

	// ==================================================================
	// Bar lookup
	// ==================================================================

	assign bar_quot = i_pix_pos / BAR_WIDTH;  // Constant divisor

	always_comb begin
		if (i_pix_pos >= LAST_BAR_START)
			bar_idx = LAST_BAR_IDX;
		else
			bar_idx = bar_quot[BAR_IDX_W-1:0];
	end

	assign bar_color = BAR_COLOR[bar_idx];
	assign pix_sel   = i_pattern_en ? bar_color : i_pix_data;

	// ==================================================================
	// Output register
	// ==================================================================

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_pix_vld     <= 1'b0;
			o_pix_data    <= '0;
			o_frame_start <= 1'b0;
			o_line_active <= 1'b0;
		end else begin
			o_pix_vld     <= i_pix_vld;
			o_frame_start <= i_frame_start;
			o_line_active <= i_line_active;
			if (i_pix_vld)
				o_pix_data <= pix_sel;  // Holds between pixels
		end
	end

endmodule

//--- verilog/cmos_pixel_assembler.sv
// Pairs camera bytes into RGB565, first byte high; strobes come one cycle after the byte
// Swap only exchanges the red and blue fields
`timescale 1ns/1ps

module cmos_pixel_assembler
	import cam_pixel_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  cam_byte_t i_data,
	input  logic      i_hi_byte_we,
	input  logic      i_pair_done,
	input  logic      i_swap_rb,    // Static mode level
	output logic      o_pix_vld,
	output rgb565_t   o_pix_data
);

	cam_byte_t data_d0;    // Port register
	cam_byte_t data_d1;    // Aligned with the controller strobes
	cam_byte_t hi_byte;
	rgb565_t   pair_word;
	rgb565_t   pix_fmt;

	// ==================================================================
	// Data path
	// ==================================================================

	always_ff @(posedge i_clk) begin
		data_d0 <= i_data;
		data_d1 <= data_d0;
		if (i_hi_byte_we)
			hi_byte <= data_d1;
		if (i_pair_done)
			o_pix_data <= pix_fmt;
	end

	assign pair_word = {hi_byte, data_d1};

	// Green stays in place
	assign pix_fmt = i_swap_rb ?
		{pair_word[4:0], pair_word[10:5], pair_word[15:11]} :
		pair_word;

	// ==================================================================
	// Valid strobe
	// ==================================================================

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_pix_vld <= 1'b0;
		else
			o_pix_vld <= i_pair_done;
	end

	// Bytes arrive every cycle in a line, so the high byte is always one cycle old
	a_pair_after_hi: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_pair_done |-> $past(i_hi_byte_we));

endmodule

//--- verilog/cmos_capture_ctrl.sv
// Camera sync tracking; bytes are ignored until the first vsync rise after reset
// Href is treated as a byte valid on every cycle it is high
`timescale 1ns/1ps
`include "cam_settings.svh"

module cmos_capture_ctrl
	import cam_timing_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_rst_n,
	input  logic     i_vsync,
	input  logic     i_href,
	input  logic     i_pix_vld,     // From the assembler, advances the position
	output logic     o_hi_byte_we,  // First byte of a pair
	output logic     o_pair_done,   // Second byte of a pair
	output pix_pos_t o_pix_pos,
	output logic     o_frame_start,
	output logic     o_line_active
);

	localparam pix_pos_t POS_LAST = pix_pos_t'(`CAM_H_PIXELS - 1);

	logic           vsync_d0;
	logic           vsync_d1;
	logic           href_d0;
	logic           href_d1;
	logic           vsync_rise;
	logic           href_rise;
	logic           byte_en;     // Registered byte belongs to an active line
	logic           byte_phase;  // High while waiting for the second byte
	capture_state_e state;
	capture_state_e state_nxt;

	// ==================================================================
	// Sync input registers and edge detect
	// ==================================================================

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			vsync_d0 <= 1'b0;
			vsync_d1 <= 1'b0;
			href_d0  <= 1'b0;
			href_d1  <= 1'b0;
		end else begin
			vsync_d0 <= i_vsync;
			vsync_d1 <= vsync_d0;
			href_d0  <= i_href;
			href_d1  <= href_d0;
		end
	end

	assign vsync_rise = vsync_d0 & ~vsync_d1;
	assign href_rise  = href_d0 & ~href_d1;

	// ==================================================================
	// Frame / line FSM
	// ==================================================================

	always_comb begin
		state_nxt = state;
		case (state)
			CAP_WAIT_FRAME: begin
				if (vsync_rise)
					state_nxt = CAP_LINE_IDLE;
			end
			CAP_LINE_IDLE: begin
				if (!vsync_rise && href_rise)
					state_nxt = CAP_LINE_ACTIVE;
			end
			CAP_LINE_ACTIVE: begin
				if (vsync_rise || !href_d0)
					state_nxt = CAP_LINE_IDLE;
			end
			default: state_nxt = CAP_WAIT_FRAME;
		endcase
	end

	// A line only counts once it starts cleanly inside a frame
	assign byte_en = !vsync_rise &&
		((state == CAP_LINE_ACTIVE && href_d0) || (state == CAP_LINE_IDLE && href_rise));

	// Strobes are registered, so they line up with the assembler's second data stage
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state         <= CAP_WAIT_FRAME;
			byte_phase    <= 1'b0;
			o_hi_byte_we  <= 1'b0;
			o_pair_done   <= 1'b0;
			o_frame_start <= 1'b0;
			o_line_active <= 1'b0;
		end else begin
			state         <= state_nxt;
			o_frame_start <= vsync_rise;
			o_line_active <= byte_en;
			o_hi_byte_we  <= byte_en & ~byte_phase;
			o_pair_done   <= byte_en & byte_phase;
			// Phase drops whenever href does, so an odd last byte is lost
			if (byte_en)
				byte_phase <= ~byte_phase;
			else
				byte_phase <= 1'b0;
		end
	end

	// ==================================================================
	// Horizontal position
	// ==================================================================

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_pix_pos <= '0;
		end else if (vsync_rise || href_rise) begin
			o_pix_pos <= '0;  // Wins over a pixel still leaving the last line
		end else if (i_pix_vld) begin
			if (o_pix_pos == POS_LAST)
				o_pix_pos <= '0;
			else
				o_pix_pos <= o_pix_pos + 1'b1;
		end
	end

	a_strobes_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(o_hi_byte_we && o_pair_done));

	a_pos_in_line: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_pix_pos < `CAM_H_PIXELS);

endmodule

//--- verilog/cam_timing_pkg.sv
// Pixel position type and capture FSM states for the camera timing path
`include "cam_settings.svh"

package cam_timing_pkg;

	// Horizontal pixel index within a line
	typedef logic [`CAM_POS_BITS-1:0] pix_pos_t;

	// Capture FSM
	typedef enum logic [1:0] {
		CAP_WAIT_FRAME  = 2'd0,  // No frame start seen yet
		CAP_LINE_IDLE   = 2'd1,  // In a frame, between lines
		CAP_LINE_ACTIVE = 2'd2   // Href high, bytes arriving
	} capture_state_e;

endpackage

//--- verilog/cam_pixel_pkg.sv
// Camera byte and RGB565 pixel types plus the colour-bar table
// Table length follows CAM_BAR_COUNT, values are in left to right order
`include "cam_settings.svh"

package cam_pixel_pkg;

	// ==================================================================
	// Data types
	// ==================================================================

	// One byte from the sensor data bus
	typedef logic [7:0] cam_byte_t;

	// Packed pixel, red[15:11] green[10:5] blue[4:0]
	typedef logic [15:0] rgb565_t;

	// ==================================================================
	// Colour-bar pattern
	// ==================================================================

	// Bar colours, index 0 is the leftmost bar
	localparam rgb565_t BAR_COLOR [`CAM_BAR_COUNT] = '{
		16'h001F,  // Bar 0
		16'h07E0,  // Bar 1
		16'hF800,  // Bar 2
		16'h07FF,  // Bar 3
		16'hFFE0,  // Bar 4
		16'hF81F,  // Bar 5
		16'hFFFF,  // Bar 6, all fields full
		16'h0000   // Bar 7, all fields empty
	};

endpackage

//--- verilog/cam_settings.svh
// Fixed capture geometry for a 1280-pixel line split into eight equal bars
// Bar width times bar count must equal the line length
`ifndef CAM_SETTINGS_SVH
`define CAM_SETTINGS_SVH

// ======================================================================
// Line geometry
// ======================================================================

// Pixels per active line
`define CAM_H_PIXELS 1280

// Width of the horizontal position counter, must hold CAM_H_PIXELS-1
`define CAM_POS_BITS 12

// ======================================================================
// Colour-bar test pattern
// ======================================================================

`define CAM_BAR_WIDTH 160 // Pixels per bar
`define CAM_BAR_COUNT 8   // Bars per line

`endif
